/* common/fmul_pkg.sv */
`default_nettype none

package fmul_pkg;

    // binary32 field widths
    localparam int FP_W   = 32;
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int MANT_W = FRAC_W + 1;      // fraction plus hidden bit
    localparam int SEXP_W = EXP_W + 2;       // headroom for over/underflow

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;           // all-ones exponent

    typedef logic [FP_W-1:0]            fp32_t;
    typedef logic [EXP_W-1:0]           exp_t;
    typedef logic [MANT_W-1:0]          mant_t;
    typedef logic [2*MANT_W-1:0]        prod_t;
    typedef logic signed [SEXP_W-1:0]   sexp_t;

    // canonical quiet NaN, sign clear
    localparam fp32_t QNAN = 32'h7fc0_0000;

    // infinity without its sign bit
    localparam logic [FP_W-2:0] INF_MAG = {8'hff, 23'd0};

    // shift-and-add multiplier sequencing
    typedef enum logic [1:0] {
        MC_IDLE,
        MC_RUN,
        MC_FINISH
    } mcycle_state_t;

    // top level sequencing
    typedef enum logic [1:0] {
        FM_IDLE,
        FM_MUL,
        FM_PACK
    } fmul_state_t;

endpackage

`default_nettype wire

/* logic/fp_unpack.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_unpack (
    input  wire fmul_pkg::fp32_t op,
    output logic                 sign,
    output fmul_pkg::exp_t       exp,
    output fmul_pkg::mant_t      mant,
    output logic                 is_zero,
    output logic                 is_inf,
    output logic                 is_nan
);

    logic [fmul_pkg::FRAC_W-1:0] frac;
    logic                        exp_all_ones;
    logic                        frac_nonzero;

    assign sign = op[fmul_pkg::FP_W-1];
    assign exp  = op[fmul_pkg::FP_W-2:fmul_pkg::FRAC_W];
    assign frac = op[fmul_pkg::FRAC_W-1:0];

    assign exp_all_ones = (exp == fmul_pkg::exp_t'(fmul_pkg::EXP_MAX));
    assign frac_nonzero = |frac;

    // zero exponent covers true zero and subnormals, both flushed
    assign is_zero = (exp == '0);
    assign is_inf  = exp_all_ones && !frac_nonzero;
    assign is_nan  = exp_all_ones && frac_nonzero;

    always_comb begin
        if (is_zero) begin
            mant = '0;                       // flushed, no hidden bit
        end else begin
            mant = {1'b1, frac};             // restore hidden one
        end
    end

endmodule

`default_nettype wire

/* mcycle/mcycle_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module mcycle_mul #(
    parameter int WIDTH = fmul_pkg::MANT_W
) (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               start,
    input  wire logic [WIDTH-1:0]   operand1,
    input  wire logic [WIDTH-1:0]   operand2,
    output logic [2*WIDTH-1:0]      product,
    output logic                    busy,
    output logic                    done
);

    localparam int CNT_W = $clog2(WIDTH);

    fmul_pkg::mcycle_state_t state;
    logic [CNT_W-1:0]        count;         // multiplier bits consumed

    logic [2*WIDTH-1:0]      mcand;         // shifts left each step
    logic [WIDTH-1:0]        mplier;        // shifts right each step
    logic [2*WIDTH-1:0]      acc;

    logic                    load;
    logic                    last_step;

    assign load      = (state == fmul_pkg::MC_IDLE) && start;
    assign last_step = (count == CNT_W'(WIDTH - 1));

    // sequencing, one multiplier bit per run cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fmul_pkg::MC_IDLE;
            count <= '0;
        end else begin
            case (state)
                fmul_pkg::MC_IDLE: begin
                    if (start) begin
                        state <= fmul_pkg::MC_RUN;
                        count <= '0;
                    end
                end
                fmul_pkg::MC_RUN: begin
                    count <= count + 1'b1;
                    if (last_step) begin
                        state <= fmul_pkg::MC_FINISH;
                    end
                end
                fmul_pkg::MC_FINISH: begin
                    state <= fmul_pkg::MC_IDLE;  // done lasts one cycle
                end
                default: begin
                    state <= fmul_pkg::MC_IDLE;
                end
            endcase
        end
    end

    // datapath; acc is left alone outside run so the product holds
    always_ff @(posedge clk) begin
        if (load) begin
            mcand  <= {{WIDTH{1'b0}}, operand1};
            mplier <= operand2;
            acc    <= '0;
        end else if (state == fmul_pkg::MC_RUN) begin
            if (mplier[0]) begin
                acc <= acc + mcand;            // partial product
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;
    assign busy    = (state != fmul_pkg::MC_IDLE);
    assign done    = (state == fmul_pkg::MC_FINISH);

endmodule

`default_nettype wire

/* logic/fp_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

module fp_normalize (
    input  wire fmul_pkg::prod_t  prod,
    input  wire fmul_pkg::sexp_t  exp_sum,
    input  wire logic             sign,
    output fmul_pkg::fp32_t       packed_out
);

    localparam int P_TOP = 2 * fmul_pkg::MANT_W - 1;   // product msb

    logic [fmul_pkg::FRAC_W-1:0] frac;
    fmul_pkg::sexp_t             exp_final;
    logic                        overflow;
    logic                        underflow;

    // product of two 1.x values lies in [1,4)
    always_comb begin
        if (prod[P_TOP]) begin
            frac      = prod[P_TOP-1 -: fmul_pkg::FRAC_W];   // >= 2, shift right once
            exp_final = exp_sum + fmul_pkg::sexp_t'(1);
        end else begin
            frac      = prod[P_TOP-2 -: fmul_pkg::FRAC_W];   // leading one at bit 46
            exp_final = exp_sum;
        end
    end

    // low product bits are simply dropped, round toward zero
    assign overflow  = (exp_final >= fmul_pkg::sexp_t'(fmul_pkg::EXP_MAX));
    assign underflow = (exp_final <= fmul_pkg::sexp_t'(0));

    always_comb begin
        if (overflow) begin
            packed_out = {sign, fmul_pkg::INF_MAG};
        end else if (underflow) begin
            packed_out = {sign, {(fmul_pkg::FP_W-1){1'b0}}};     // no subnormal output
        end else begin
            packed_out = {sign, exp_final[fmul_pkg::EXP_W-1:0], frac};
        end
    end

endmodule

`default_nettype wire

/* logic/fmul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fmul_unit (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic            start,
    input  wire fmul_pkg::fp32_t src1,
    input  wire fmul_pkg::fp32_t src2,
    output fmul_pkg::fp32_t      result,
    output logic                 busy,
    output logic                 done
);

    fmul_pkg::fmul_state_t state;

    logic            sign1, sign2;
    fmul_pkg::exp_t  exp1, exp2;
    fmul_pkg::mant_t mant1, mant2;
    logic            zero1, zero2;
    logic            inf1, inf2;
    logic            nan1, nan2;

    logic            accept;
    logic            special;
    logic            res_sign;
    fmul_pkg::sexp_t exp_sum;
    fmul_pkg::fp32_t special_result;

    logic            mul_start;
    logic            mul_done;
    fmul_pkg::prod_t mul_product;
    logic            sign_q;        // held for the normal path
    fmul_pkg::sexp_t exp_sum_q;
    fmul_pkg::fp32_t norm_result;

    fp_unpack u_unpack1 (
        .op      (src1),
        .sign    (sign1),
        .exp     (exp1),
        .mant    (mant1),
        .is_zero (zero1),
        .is_inf  (inf1),
        .is_nan  (nan1)
    );

    fp_unpack u_unpack2 (
        .op      (src2),
        .sign    (sign2),
        .exp     (exp2),
        .mant    (mant2),
        .is_zero (zero2),
        .is_inf  (inf2),
        .is_nan  (nan2)
    );

    assign busy      = (state == fmul_pkg::FM_MUL);
    assign done      = (state == fmul_pkg::FM_PACK);
    assign accept    = start && !busy;               // start while busy is dropped
    assign mul_start = accept && !special;

    assign res_sign = sign1 ^ sign2;
    assign exp_sum  = fmul_pkg::sexp_t'({2'b00, exp1}) + fmul_pkg::sexp_t'({2'b00, exp2})
                    - fmul_pkg::sexp_t'(fmul_pkg::EXP_BIAS);

    // NaN first, then inf, then zero
    always_comb begin
        special = zero1 || zero2 || inf1 || inf2 || nan1 || nan2;
        if (nan1 || nan2 || (inf1 && zero2) || (inf2 && zero1)) begin
            special_result = fmul_pkg::QNAN;
        end else if (inf1 || inf2) begin
            special_result = {res_sign, fmul_pkg::INF_MAG};
        end else begin
            special_result = {res_sign, {(fmul_pkg::FP_W-1){1'b0}}};
        end
    end

    mcycle_mul #(
        .WIDTH (fmul_pkg::MANT_W)
    ) u_mcycle_mul (
        .clk      (clk),
        .reset    (reset),
        .start    (mul_start),
        .operand1 (mant1),
        .operand2 (mant2),
        .product  (mul_product),
        .busy     (),
        .done     (mul_done)
    );

    fp_normalize u_normalize (
        .prod       (mul_product),
        .exp_sum    (exp_sum_q),
        .sign       (sign_q),
        .packed_out (norm_result)
    );

    always_ff @(posedge clk) begin
        if (mul_start) begin
            sign_q    <= res_sign;
            exp_sum_q <= exp_sum;
        end
    end

    // pack is the done cycle and can take a new start
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= fmul_pkg::FM_IDLE;
            result <= '0;
        end else begin
            case (state)
                fmul_pkg::FM_MUL: begin
                    if (mul_done) begin
                        result <= norm_result;
                        state  <= fmul_pkg::FM_PACK;
                    end
                end
                default: begin
                    if (accept && special) begin
                        result <= special_result;  // one-cycle answer
                        state  <= fmul_pkg::FM_PACK;
                    end else if (accept) begin
                        state  <= fmul_pkg::FM_MUL;
                    end else begin
                        state  <= fmul_pkg::FM_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* bench/fmul_unit_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module fmul_unit_sva (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            start,
    input wire logic            busy,
    input wire logic            done,
    input wire logic            mul_start,
    input wire fmul_pkg::fp32_t result
);

    localparam int NORMAL_LAT = 26;     // accepted start to done on the multiplier path

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done stayed high for a second cycle");

    // nothing moves the result without an accepted start or a running multiply
    result_hold: assert property (@(posedge clk) disable iff (reset)
        (!busy && !start) |=> $stable(result))
        else $error("result changed while idle");

    reset_idle: assert property (@(posedge clk)
        reset |=> (!busy && !done && result == '0))
        else $error("outputs not cleared by reset");

    normal_latency: assert property (@(posedge clk) disable iff (reset)
        mul_start |-> ##NORMAL_LAT done)
        else $error("normal path done not at the expected cycle");

endmodule

bind fmul_unit fmul_unit_sva u_fmul_unit_sva (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .busy      (busy),
    .done      (done),
    .mul_start (mul_start),
    .result    (result)
);

`default_nettype wire

/* bench/tb_fmul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fmul_unit;

    localparam string VEC_FILE    = "bench/fmul_vectors.txt";
    localparam int    CLK_HALF    = 10;             // 20 ns period
    localparam int    LAT_NORMAL  = 26;             // start to done through the multiplier
    localparam int    LAT_SPECIAL = 1;
    localparam int    STRAY_CYCLE = 5;              // when the ignored start goes in

    logic            clk;
    logic            reset;
    logic            start;
    fmul_pkg::fp32_t src1;
    fmul_pkg::fp32_t src2;
    fmul_pkg::fp32_t result;
    logic            busy;
    logic            done;

    int          err_count   = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    logic [31:0] lfsr_state;

    string           vec_name[$];
    fmul_pkg::fp32_t vec_a[$];
    fmul_pkg::fp32_t vec_b[$];
    fmul_pkg::fp32_t vec_exp[$];
    bit              vec_normal[$];

    fmul_unit u_fmul_unit (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .src1   (src1),
        .src2   (src2),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    always #CLK_HALF clk = ~clk;

    // run guard, limit set once the vectors are known
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_gap(output int gap);
        logic [2:0] g;
        g = '0;
        for (int n = 0; n < 3; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            g = {g[1:0], lfsr_state[0]};        // one step per bit
        end
        gap = int'(g);
    endtask

    task automatic check_result(input string name, input string what,
                                input fmul_pkg::fp32_t expected, input fmul_pkg::fp32_t actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", name, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %b actual %b", name, what, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERR %s latency expected %0d actual %0d", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic record_outcome(input string name, input int errs_before, input int cycles);
        if (err_count == errs_before) begin
            pass_count++;
            $display("test %s ok after %0d cycles", name, cycles);
        end else begin
            fail_count++;
            $display("test %s FAILED", name);
        end
    endtask

    task automatic load_vectors();
        int              fd;
        int              n;
        string           line;
        string           name;
        string           path;
        fmul_pkg::fp32_t a;
        fmul_pkg::fp32_t b;
        fmul_pkg::fp32_t e;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("could not open vector file %s", VEC_FILE);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line[0] == "#") continue;   // header lines
            n = $sscanf(line, "%s %h %h %h %s", name, a, b, e, path);
            if (n != 5) continue;
            vec_name.push_back(name);
            vec_a.push_back(a);
            vec_b.push_back(b);
            vec_exp.push_back(e);
            vec_normal.push_back(path == "normal");
        end
        $fclose(fd);
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = err_count;
        check_flag("reset_state", "busy", 1'b0, busy);
        check_flag("reset_state", "done", 1'b0, done);
        check_result("reset_state", "result", '0, result);
        record_outcome("reset_state", errs_before, 0);
    endtask

    // entered and left on a falling edge
    task automatic run_test(input string name, input fmul_pkg::fp32_t a,
                            input fmul_pkg::fp32_t b, input fmul_pkg::fp32_t expected,
                            input bit normal, input int gap);
        int   cycles;
        int   errs_before;
        int   want_lat;
        int   i;
        logic seen;
        errs_before = err_count;
        want_lat    = normal ? LAT_NORMAL : LAT_SPECIAL;
        cycles      = 0;
        seen        = 1'b0;
        src1        = a;
        src2        = b;
        start       = 1'b1;
        while (!seen && cycles < LAT_NORMAL + 4) begin
            @(negedge clk);
            cycles++;
            start = 1'b0;
            if (done) begin
                seen = 1'b1;
            end else if (normal) begin
                check_flag(name, "busy", 1'b1, busy);
                if (cycles == STRAY_CYCLE) begin
                    src1  = 32'hc200_0000;          // -32 times 32, new sign and scale if taken
                    src2  = 32'h4200_0000;
                    start = 1'b1;
                end
            end else begin
                check_flag(name, "busy", 1'b0, busy);
            end
        end
        if (!seen) begin
            $display("%s: done never pulsed within %0d cycles", name, cycles);
            err_count++;
        end else begin
            check_result(name, "result", expected, result);
            check_flag(name, "busy at done", 1'b0, busy);
            check_latency(name, want_lat, cycles);
        end
        for (i = 0; i <= gap; i++) begin
            @(negedge clk);
            check_flag(name, "done after pulse", 1'b0, done);
            check_result(name, "held result", expected, result);
        end
        record_outcome(name, errs_before, cycles);
    endtask

    initial begin
        int gap;
        int k;
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        src1       = '0;
        src2       = '0;
        lfsr_state = 32'hd6a3;
        load_vectors();
        if (vec_name.size() == 0) begin
            $display("no test vectors were loaded, nothing to run");
            $display("** FAIL **");
            $finish;
        end
        cycle_limit = vec_name.size() * 40 + 100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        for (k = 0; k < vec_name.size(); k++) begin
            pick_gap(gap);
            run_test(vec_name[k], vec_a[k], vec_b[k], vec_exp[k], vec_normal[k], gap);
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/fmul_vectors.txt */
# columns: name src1 src2 expected path, operands and result as binary32 hex
# path is special (answer one cycle after start) or normal (through the multiplier)
reset_clear_1p5x2     3fc00000 40000000 40400000 normal
norm_1p5x1p5          3fc00000 3fc00000 40100000 normal
norm_neg3xhalf        c0400000 3f000000 bfc00000 normal
norm_3x7              40400000 40e00000 41a80000 normal
norm_neg2p5xneg4      c0200000 c0800000 41200000 normal
norm_one_x_one        3f800000 3f800000 3f800000 normal
norm_neg_one          bf800000 3f800000 bf800000 normal
norm_1p25sq           3fa00000 3fa00000 3fc80000 normal
norm_1p75sq           3fe00000 3fe00000 40440000 normal
norm_5x5              40a00000 40a00000 41c80000 normal
norm_neg6             bf400000 41000000 c0c00000 normal
norm_tenth_x10        3dcccccd 41200000 3f800000 normal
norm_third_x3         3eaaaaab 40400000 3f800000 normal
norm_trunc_low        3f800001 3f800001 3f800002 normal
norm_trunc_low_neg    bf800001 3f800001 bf800002 normal
norm_trunc_high       3fffffff 3fffffff 407ffffe normal
norm_big_half         7f000000 3f000000 7e800000 normal
norm_max              7f000000 3fffffff 7f7fffff normal
edge_min_carry        00c00000 3f400000 00900000 normal
ovf_pos               7f000000 40000000 7f800000 normal
ovf_carry_neg         ff400000 3fc00000 ff800000 normal
ovf_huge              7f7fffff 7f7fffff 7f800000 normal
unf_edge              00800000 3f000000 00000000 normal
unf_edge_neg          80800000 3f000000 80000000 normal
unf_deep              0c000000 0c000000 00000000 normal
unf_deep_neg          8c000000 0c000000 80000000 normal
sub_pos               00400000 3f800000 00000000 special
sub_neg               80000001 40000000 80000000 special
zero_pos              00000000 40400000 00000000 special
zero_neg              80000000 40400000 80000000 special
zero_negop            00000000 c0400000 80000000 special
zero_zero             80000000 80000000 00000000 special
inf_pos               7f800000 40000000 7f800000 special
inf_neg               7f800000 c0000000 ff800000 special
inf_inf               ff800000 7f800000 ff800000 special
nan_quiet             7fc00000 3f800000 7fc00000 special
nan_neg               3f800000 ffc12345 7fc00000 special
nan_sig_zero          7f800001 00000000 7fc00000 special
nan_x_inf             7f800000 7fffffff 7fc00000 special
inf_x_zero            7f800000 00000000 7fc00000 special
zero_x_ninf           80000000 ff800000 7fc00000 special
inf_x_sub             7f800000 00000001 7fc00000 special
norm_after_special    40400000 40e00000 41a80000 normal

/* fmul_unit.f */
common/fmul_pkg.sv
logic/fp_unpack.sv
mcycle/mcycle_mul.sv
logic/fp_normalize.sv
logic/fmul_unit.sv
bench/fmul_unit_sva.sv
bench/tb_fmul_unit.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_fmul_unit
FILELIST   := fmul_unit.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := ** PASS **
VFLAGS     := --binary --timing --assert -j 0 --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
